/* hdl/cpu_timing_pkg.sv */
// Cycle kind enum, timing select vector and bit positions, strobe state enum, debounce default
`default_nettype none

package cpu_timing_pkg;

	// Kind of processor cycle
	// Loaded at the end of every cycle and decoded into ss11..ss15
	typedef enum logic [2:0] {
		CYC_REG    = 3'd0,
		CYC_MEM_RD = 3'd1,
		CYC_MEM_WR = 3'd2,
		CYC_ALU    = 3'd3,
		CYC_IF     = 3'd4
	} cycle_kind_t;

	// Timing select lines, always one-hot
	typedef logic [4:0] timing_sel_t;

	// Bit positions inside timing_sel_t
	localparam int SEL_SS11 = 0;
	localparam int SEL_SS12 = 1;
	localparam int SEL_SS13 = 2;
	localparam int SEL_SS14 = 3;
	localparam int SEL_SS15 = 4;

	// Strobe generator states
	// W suffix marks a hold state, B marks the back half of a strobe
	typedef enum logic [2:0] {
		ST_GOT  = 3'd0,
		ST_GOTW = 3'd1,
		ST_ST1  = 3'd2,
		ST_ST1W = 3'd3,
		ST_ST1B = 3'd4,
		ST_PGOT = 3'd5,
		ST_ST2  = 3'd6,
		ST_ST2B = 3'd7
	} strob_state_t;

	// Cycles a front-panel key must stay stable before it is accepted
	localparam int DEBOUNCE_DEFAULT = 4;

endpackage

`default_nettype wire

/* hdl/strob_if.sv */
// Strobe bundle interface with source, decoder and guard modports
`timescale 1ns/1ps
`default_nettype none

interface strob_if;

	// One level per strobe state
	logic got;
	logic strob1;
	logic strob1b;
	logic strob2;
	logic strob2b;
	// Single-cycle pulse, loads the next cycle
	logic ldstate;

	// Strobe generator drives everything
	modport src (
		output got, strob1, strob1b, strob2, strob2b, ldstate
	);

	// Cycle decoder only needs the load pulse
	modport dec (
		input ldstate
	);

	// Interface guard samples requests during strob1
	modport guard (
		input ldstate, strob1
	);

endinterface

`default_nettype wire

/* hdl/panel_step.sv */
// Front-panel key synchronizer, debouncer and step pulse generator
`timescale 1ns/1ps
`default_nettype none

module panel_step #(
	parameter int DEBOUNCE_CYCLES = 4
) (
	input  logic clk_sys,
	input  logic rst,
	input  logic mode,
	input  logic step,
	output logic mode_s,
	output logic step_pulse
);

	// Counter wide enough for the full debounce window
	localparam int CNT_W = $clog2(DEBOUNCE_CYCLES + 1);
	// Key slots
	localparam int K_MODE = 0;
	localparam int K_STEP = 1;

	logic [1:0] key_raw;
	// Two-flop synchronizer per key
	logic [1:0] sync_a;
	logic [1:0] sync_b;
	// Accepted key levels
	logic [1:0] key_db;
	// Synchronized level has been different long enough
	logic [1:0] settle;
	logic [CNT_W-1:0] cnt [2];

	assign key_raw = {step, mode};

	always_comb begin
		for (int k = 0; k < 2; k++) begin
			settle[k] = (sync_b[k] != key_db[k]) && (cnt[k] == CNT_W'(DEBOUNCE_CYCLES - 1));
		end
	end

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			sync_a <= '0;
			sync_b <= '0;
			key_db <= '0;
			step_pulse <= 1'b0;
			for (int k = 0; k < 2; k++) begin
				cnt[k] <= '0;
			end
		end else begin
			sync_a <= key_raw;
			sync_b <= sync_a;
			for (int k = 0; k < 2; k++) begin
				if (sync_b[k] == key_db[k]) begin
					// Bounce back, start over
					cnt[k] <= '0;
				end else if (settle[k]) begin
					key_db[k] <= sync_b[k];
					cnt[k] <= '0;
				end else begin
					cnt[k] <= cnt[k] + 1'b1;
				end
			end
			// One pulse on the accepted rising edge of STEP
			step_pulse <= settle[K_STEP] & sync_b[K_STEP];
		end
	end

	// Debounced MODE level
	assign mode_s = key_db[K_MODE];

endmodule

`default_nettype wire

/* hdl/cycle_decoder.sv */
// Current cycle register and decoder into the one-hot timing select lines
`timescale 1ns/1ps
`default_nettype none

module cycle_decoder (
	input  logic                       clk_sys,
	input  logic                       rst,
	input  cpu_timing_pkg::cycle_kind_t next_cycle,
	strob_if.dec                       bus,
	output cpu_timing_pkg::timing_sel_t sel,
	output cpu_timing_pkg::cycle_kind_t cycle
);

	import cpu_timing_pkg::*;

	// Cycle register
	// Reset to a short cycle so the first one needs no memory
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			cycle <= CYC_ALU;
		end else if (bus.ldstate) begin
			// New kind shows up on the clock after ldstate
			cycle <= next_cycle;
		end
	end

	// Select decode
	always_comb begin
		sel = '0;
		case (cycle)
			// Register transfer with STROB2
			CYC_REG: begin
				sel[SEL_SS11] = 1'b1;
			end
			// Memory read with STROB2 that waits for ok_mem
			CYC_MEM_RD: begin
				sel[SEL_SS12] = 1'b1;
			end
			// Memory write without STROB2 that waits for ok_mem
			CYC_MEM_WR: begin
				sel[SEL_SS13] = 1'b1;
			end
			// Interface cycle without STROB2
			CYC_IF: begin
				sel[SEL_SS15] = 1'b1;
			end
			// ALU cycle and any undefined code
			default: begin
				sel[SEL_SS14] = 1'b1;
			end
		endcase
	end

	// Exactly one select line at any time
	sel_onehot_a: assert property (
		@(posedge clk_sys) disable iff (rst)
		$onehot(sel)
	) else $error("timing select not one-hot");

endmodule

`default_nettype wire

/* hdl/iface_guard.sv */
// Pending interface transfer flag and the cycle-end blocking signal
`timescale 1ns/1ps
`default_nettype none

module iface_guard (
	input  logic clk_sys,
	input  logic rst,
	input  logic iface_req,
	input  logic iface_done,
	input  logic oken,
	strob_if.guard bus,
	output logic if_busy
);

	// Transfer pending
	logic zw;

	// Set during strob1, cleared by done
	// Done has priority when both arrive together
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			zw <= 1'b0;
		end else if (iface_done) begin
			zw <= 1'b0;
		end else if (iface_req && bus.strob1) begin
			zw <= 1'b1;
		end
	end

	// Only blocks while the interface is enabled
	assign if_busy = zw & oken;

	// Cycle must never end with a transfer still blocking it
	no_load_busy_a: assert property (
		@(posedge clk_sys) disable iff (rst)
		bus.ldstate |-> !if_busy
	) else $error("ldstate while interface busy");

endmodule

`default_nettype wire

/* hdl/strob_gen.sv */
// Strobe state machine producing GOT, STROB1, STROB2 and the ldstate pulse
`timescale 1ns/1ps
`default_nettype none

module strob_gen (
	input  logic                        clk_sys,
	input  logic                        rst,
	input  cpu_timing_pkg::timing_sel_t sel,
	input  logic                        ok_mem,
	input  logic                        if_busy,
	input  logic                        mode_s,
	input  logic                        step_pulse,
	strob_if.src                        bus
);

	import cpu_timing_pkg::*;

	strob_state_t state;
	strob_state_t state_nx;

	logic ss11;
	logic ss12;
	logic ss13;
	logic ss14;
	logic ss15;
	// Ready to start STROB1
	logic es1;
	logic has_strob2;
	logic no_strob2;
	// Leave STROB1 front
	logic step_trig;

	assign ss11 = sel[SEL_SS11];
	assign ss12 = sel[SEL_SS12];
	assign ss13 = sel[SEL_SS13];
	assign ss14 = sel[SEL_SS14];
	assign ss15 = sel[SEL_SS15];

	// Memory cycles wait for ok_mem
	assign es1 = ss11 | ((ss12 | ss13) & ok_mem) | ss14 | ss15;
	assign has_strob2 = ss11 | ss12;
	assign no_strob2 = ss13 | ss14 | ss15;
	// Step mode off lets every cycle run
	assign step_trig = ~mode_s | step_pulse;

	always_comb begin
		state_nx = state;
		case (state)
			ST_GOT: begin
				state_nx = es1 ? ST_ST1 : ST_GOTW;
			end
			// Memory not ready yet
			ST_GOTW: begin
				if (es1) begin
					state_nx = ST_ST1;
				end
			end
			ST_ST1: begin
				state_nx = step_trig ? ST_ST1B : ST_ST1W;
			end
			// Parked until the STEP key
			ST_ST1W: begin
				if (step_trig) begin
					state_nx = ST_ST1B;
				end
			end
			ST_ST1B: begin
				if (has_strob2) begin
					state_nx = ST_ST2;
				end else if (no_strob2 && !if_busy) begin
					state_nx = ST_GOT;
				end else begin
					state_nx = ST_PGOT;
				end
			end
			ST_ST2: begin
				state_nx = ST_ST2B;
			end
			ST_ST2B: begin
				state_nx = if_busy ? ST_PGOT : ST_GOT;
			end
			// Interface transfer still pending
			ST_PGOT: begin
				if (!if_busy) begin
					state_nx = ST_GOT;
				end
			end
			default: begin
				state_nx = ST_GOT;
			end
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			state <= ST_GOT;
		end else begin
			state <= state_nx;
		end
	end

	// Strobes straight from the state, no strobe in hold states
	assign bus.got = (state == ST_GOT);
	assign bus.strob1 = (state == ST_ST1);
	assign bus.strob1b = (state == ST_ST1B);
	assign bus.strob2 = (state == ST_ST2);
	assign bus.strob2b = (state == ST_ST2B);
	// Cycle end in whichever state closes it
	assign bus.ldstate = ~if_busy & ((state == ST_PGOT)
		| ((state == ST_ST1B) & no_strob2)
		| (state == ST_ST2B));

	// STROB2 only follows STROB1 back of a long cycle
	strob2_entry_a: assert property (
		@(posedge clk_sys) disable iff (rst)
		$rose(bus.strob2) |-> $past(state == ST_ST1B && has_strob2)
	) else $error("strob2 entered from wrong state");

	// Never two strobes at once
	strob_excl_a: assert property (
		@(posedge clk_sys) disable iff (rst)
		$onehot0({bus.got, bus.strob1, bus.strob1b, bus.strob2, bus.strob2b})
	) else $error("strobes overlap");

endmodule

`default_nettype wire

/* hdl/cpu_timing_top.sv */
// Top level of the cycle timing unit with the strobe bundle broken out to ports
`timescale 1ns/1ps
`default_nettype none

module cpu_timing_top #(
	parameter int DEBOUNCE_CYCLES = cpu_timing_pkg::DEBOUNCE_DEFAULT
) (
	input  logic                        clk_sys,
	input  logic                        rst,
	input  cpu_timing_pkg::cycle_kind_t next_cycle,
	input  logic                        ok_mem,
	input  logic                        iface_req,
	input  logic                        iface_done,
	input  logic                        oken,
	input  logic                        mode,
	input  logic                        step,
	output logic                        got,
	output logic                        strob1,
	output logic                        strob1b,
	output logic                        strob2,
	output logic                        strob2b,
	output logic                        ldstate,
	output cpu_timing_pkg::cycle_kind_t cycle
);

	import cpu_timing_pkg::*;

	// Strobes and cycle load pulse
	strob_if bus ();

	timing_sel_t sel;
	logic if_busy;
	logic mode_s;
	logic step_pulse;

	// Front-panel keys
	panel_step #(
		.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)
	) panel_step_inst (
		.clk_sys    (clk_sys),
		.rst        (rst),
		.mode       (mode),
		.step       (step),
		.mode_s     (mode_s),
		.step_pulse (step_pulse)
	);

	// Cycle kind register and select decode
	cycle_decoder cycle_decoder_inst (
		.clk_sys    (clk_sys),
		.rst        (rst),
		.next_cycle (next_cycle),
		.bus        (bus.dec),
		.sel        (sel),
		.cycle      (cycle)
	);

	// Interface transfer hold
	iface_guard iface_guard_inst (
		.clk_sys    (clk_sys),
		.rst        (rst),
		.iface_req  (iface_req),
		.iface_done (iface_done),
		.oken       (oken),
		.bus        (bus.guard),
		.if_busy    (if_busy)
	);

	// Strobe sequencer
	strob_gen strob_gen_inst (
		.clk_sys    (clk_sys),
		.rst        (rst),
		.sel        (sel),
		.ok_mem     (ok_mem),
		.if_busy    (if_busy),
		.mode_s     (mode_s),
		.step_pulse (step_pulse),
		.bus        (bus.src)
	);

	// Strobes out to the pins
	assign got = bus.got;
	assign strob1 = bus.strob1;
	assign strob1b = bus.strob1b;
	assign strob2 = bus.strob2;
	assign strob2b = bus.strob2b;
	assign ldstate = bus.ldstate;

endmodule

`default_nettype wire

/* testbench/tb_cpu_timing.sv */
// Directed testbench for the cycle timing unit with reference sequence model and watchdog
`timescale 1ns/1ps
`default_nettype none

module tb_cpu_timing;

	import cpu_timing_pkg::*;

	localparam int CLK_PERIOD = 40;
	localparam int WAIT_LIMIT = 40;
	localparam int PRESS_CLOCKS = 8;
	localparam int HOLD_CLOCKS = 6;
	localparam int RANDOM_CYCLES = 8;
	// Worst-case clocks per test, short, strob2, memory, iface, step, loading
	localparam int WORST_CLOCKS = 12 + 16 + 24 + 40 + 120 + 60;
	localparam int WATCHDOG_NS = CLK_PERIOD * WORST_CLOCKS * 4;

	logic clk_sys;
	logic rst;
	cycle_kind_t next_cycle;
	logic ok_mem;
	logic iface_req;
	logic iface_done;
	logic oken;
	logic mode;
	logic step;
	logic got;
	logic strob1;
	logic strob1b;
	logic strob2;
	logic strob2b;
	logic ldstate;
	cycle_kind_t cycle;

	int errors;
	int checks;
	int tests_run;
	logic [31:0] rng;

	cpu_timing_top #(
		.DEBOUNCE_CYCLES(2)
	) cpu_timing_top_inst (
		.clk_sys    (clk_sys),
		.rst        (rst),
		.next_cycle (next_cycle),
		.ok_mem     (ok_mem),
		.iface_req  (iface_req),
		.iface_done (iface_done),
		.oken       (oken),
		.mode       (mode),
		.step       (step),
		.got        (got),
		.strob1     (strob1),
		.strob1b    (strob1b),
		.strob2     (strob2),
		.strob2b    (strob2b),
		.ldstate    (ldstate),
		.cycle      (cycle)
	);

	initial begin
		clk_sys = 1'b0;
		forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
	end

	// Hard stop in case a wait loop never returns
	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns, simulation stopped", WATCHDOG_NS);
		$display("Test FAILED");
		$finish;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	// Cycles with STROB2
	function automatic logic is_long(input cycle_kind_t kind);
		return (kind == CYC_REG) || (kind == CYC_MEM_RD);
	endfunction

	function automatic int expected_clocks(input cycle_kind_t kind);
		return is_long(kind) ? 5 : 3;
	endfunction

	// Expected {got, strob1, strob1b, strob2, strob2b, ldstate} per clock of a ready cycle
	function automatic logic [5:0] expected_vec(input cycle_kind_t kind, input int idx);
		case (idx)
			0: return 6'b100000;
			1: return 6'b010000;
			// Short cycles end in STROB1 back
			2: return is_long(kind) ? 6'b001000 : 6'b001001;
			3: return 6'b000100;
			4: return 6'b000011;
			default: return 6'b000000;
		endcase
	endfunction

	task automatic compare_cycle(input string name, input cycle_kind_t exp, input cycle_kind_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("[FAIL] %s: expected %s (%0d), actual %s (%0d)",
				name, exp.name(), exp, act.name(), act);
		end
	endtask

	task automatic compare_count(input string name, input string what, input int exp, input int act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("[FAIL] %s: %s expected %0d, actual %0d", name, what, exp, act);
		end
	endtask

	task automatic report_test(input string name, input int err_before);
		tests_run++;
		$display("%s finished with %0d errors", name, errors - err_before);
	endtask

	task automatic wait_ldstate(input string name);
		int waited;
		waited = 0;
		do begin
			@(negedge clk_sys);
			waited++;
		end while (!ldstate && waited < WAIT_LIMIT);
		if (!ldstate) begin
			errors++;
			$display("%s: no ldstate within %0d clocks", name, WAIT_LIMIT);
		end
	endtask

	// Next cycle after the coming ldstate has this kind
	task automatic load_kind(input string name, input cycle_kind_t kind);
		@(posedge clk_sys);
		next_cycle <= kind;
		wait_ldstate(name);
	endtask

	// Follow one ready cycle from GOT to ldstate and check it against the model
	task automatic observe_cycle(input string name, input cycle_kind_t kind);
		int clocks;
		int mism;
		int waited;
		logic done;
		logic [5:0] vec;
		clocks = 0;
		mism = 0;
		waited = 0;
		done = 1'b0;
		do begin
			@(negedge clk_sys);
			waited++;
		end while (!got && waited < WAIT_LIMIT);
		if (!got) begin
			errors++;
			$display("%s: GOT never appeared within %0d clocks", name, WAIT_LIMIT);
			return;
		end
		compare_cycle(name, kind, cycle);
		while (!done && clocks < WAIT_LIMIT) begin
			vec = {got, strob1, strob1b, strob2, strob2b, ldstate};
			if (clocks < 5 && vec !== expected_vec(kind, clocks)) begin
				mism++;
			end
			clocks++;
			if (ldstate) begin
				done = 1'b1;
			end else begin
				@(negedge clk_sys);
			end
		end
		if (!done) begin
			errors++;
			$display("%s: cycle did not end within %0d clocks", name, WAIT_LIMIT);
		end
		compare_count(name, "clocks per cycle", expected_clocks(kind), clocks);
		compare_count(name, "strobe pattern mismatches", 0, mism);
	endtask

	// Press and release STEP, each held long enough to pass the debouncer
	task automatic press_step();
		for (int i = 0; i < 2 * PRESS_CLOCKS; i++) begin
			@(posedge clk_sys);
			step <= (i < PRESS_CLOCKS);
		end
	endtask

	task automatic count_window(input int n, output int n_ld, output int n_s1b,
		output logic idle_end);
		n_ld = 0;
		n_s1b = 0;
		for (int i = 0; i < n; i++) begin
			@(negedge clk_sys);
			n_ld += ldstate;
			n_s1b += strob1b;
		end
		idle_end = !(got | strob1 | strob1b | strob2 | strob2b);
	endtask

	task automatic test_short_cycle();
		int err_before;
		err_before = errors;
		repeat (3) observe_cycle("short_cycle", CYC_ALU);
		report_test("short_cycle", err_before);
	endtask

	task automatic test_strob2_cycle();
		int err_before;
		err_before = errors;
		load_kind("strob2_cycle", CYC_REG);
		repeat (2) observe_cycle("strob2_cycle", CYC_REG);
		report_test("strob2_cycle", err_before);
	endtask

	task automatic test_memory_wait();
		int err_before;
		int n_got;
		int n_s1;
		int n_low;
		err_before = errors;
		n_got = 0;
		n_s1 = 0;
		n_low = 0;
		load_kind("memory_wait", CYC_MEM_RD);
		// Memory goes busy as the read cycle starts
		@(posedge clk_sys);
		ok_mem <= 1'b0;
		@(negedge clk_sys);
		compare_count("memory_wait", "got before wait", 1, got);
		repeat (HOLD_CLOCKS) begin
			@(negedge clk_sys);
			n_got += got;
			n_s1 += strob1;
		end
		compare_count("memory_wait", "got while waiting", 0, n_got);
		compare_count("memory_wait", "strob1 while waiting", 0, n_s1);
		@(posedge clk_sys);
		ok_mem <= 1'b1;
		do begin
			@(negedge clk_sys);
			if (!strob1) begin
				n_low++;
			end
		end while (!strob1 && n_low < WAIT_LIMIT);
		compare_count("memory_wait", "clocks from ok_mem to strob1", 1, n_low);
		wait_ldstate("memory_wait");
		report_test("memory_wait", err_before);
	endtask

	task automatic test_iface_hold();
		int err_before;
		int held_ld;
		int held_got;
		err_before = errors;
		held_ld = 0;
		held_got = 0;
		load_kind("iface_hold", CYC_IF);
		// Request spans GOT and STROB1, flag sets at the end of STROB1
		@(posedge clk_sys);
		iface_req <= 1'b1;
		@(negedge clk_sys);
		@(negedge clk_sys);
		compare_count("iface_hold", "strob1 with request", 1, strob1);
		@(posedge clk_sys);
		iface_req <= 1'b0;
		repeat (HOLD_CLOCKS) begin
			@(negedge clk_sys);
			held_ld += ldstate;
			held_got += got;
		end
		compare_count("iface_hold", "ldstate while held", 0, held_ld);
		compare_count("iface_hold", "got while held", 0, held_got);
		@(posedge clk_sys);
		iface_done <= 1'b1;
		@(posedge clk_sys);
		iface_done <= 1'b0;
		@(negedge clk_sys);
		compare_count("iface_hold", "ldstate after done", 1, ldstate);
		@(negedge clk_sys);
		compare_count("iface_hold", "got after done", 1, got);
		// Same request with the interface disabled
		@(posedge clk_sys);
		oken <= 1'b0;
		iface_req <= 1'b1;
		@(negedge clk_sys);
		compare_count("iface_hold", "strob1 with oken low", 1, strob1);
		@(posedge clk_sys);
		iface_req <= 1'b0;
		@(negedge clk_sys);
		compare_count("iface_hold", "ldstate with oken low", 1, ldstate);
		// Drop the stale flag before enabling again
		@(posedge clk_sys);
		iface_done <= 1'b1;
		@(posedge clk_sys);
		iface_done <= 1'b0;
		oken <= 1'b1;
		report_test("iface_hold", err_before);
	endtask

	task automatic test_stepping();
		int err_before;
		int waited;
		int active;
		int n_ld;
		int n_s1b;
		logic parked;
		logic prev_s1;
		logic idle_end;
		err_before = errors;
		waited = 0;
		active = 0;
		parked = 1'b0;
		prev_s1 = 1'b0;
		load_kind("stepping", CYC_ALU);
		@(posedge clk_sys);
		mode <= 1'b1;
		while (!parked && waited < WAIT_LIMIT) begin
			@(negedge clk_sys);
			waited++;
			if (!(got | strob1 | strob1b | strob2 | strob2b)) begin
				parked = 1'b1;
			end else begin
				prev_s1 = strob1;
			end
		end
		compare_count("stepping", "parked", 1, parked);
		compare_count("stepping", "strob1 before park", 1, prev_s1);
		repeat (HOLD_CLOCKS) begin
			@(negedge clk_sys);
			active += got | strob1 | strob1b | strob2 | strob2b | ldstate;
		end
		compare_count("stepping", "activity while parked", 0, active);
		// One full cycle per press
		repeat (2) begin
			fork
				press_step();
				count_window(2 * PRESS_CLOCKS, n_ld, n_s1b, idle_end);
			join
			compare_count("stepping", "ldstate per press", 1, n_ld);
			compare_count("stepping", "strob1b per press", 1, n_s1b);
			compare_count("stepping", "parked after press", 1, idle_end);
		end
		// Step mode off, presses must not disturb free running
		@(posedge clk_sys);
		mode <= 1'b0;
		wait_ldstate("stepping");
		fork
			press_step();
			repeat (3) observe_cycle("stepping", CYC_ALU);
		join
		report_test("stepping", err_before);
	endtask

	task automatic test_cycle_loading();
		int err_before;
		cycle_kind_t kind;
		cycle_kind_t nxt;
		err_before = errors;
		rng = xorshift32(rng);
		kind = cycle_kind_t'(3'(rng % 5));
		load_kind("cycle_loading", kind);
		for (int i = 0; i < RANDOM_CYCLES; i++) begin
			rng = xorshift32(rng);
			nxt = cycle_kind_t'(3'(rng % 5));
			// Presented while the current kind is being loaded
			@(posedge clk_sys);
			next_cycle <= nxt;
			observe_cycle("cycle_loading", kind);
			kind = nxt;
		end
		report_test("cycle_loading", err_before);
	endtask

	initial begin
		errors = 0;
		checks = 0;
		tests_run = 0;
		rng = 32'h34cc_a39e;
		rst = 1'b1;
		next_cycle = CYC_ALU;
		ok_mem = 1'b1;
		iface_req = 1'b0;
		iface_done = 1'b0;
		oken = 1'b1;
		mode = 1'b0;
		step = 1'b0;
		repeat (2) @(posedge clk_sys);
		rst <= 1'b0;
		test_short_cycle();
		test_strob2_cycle();
		test_memory_wait();
		test_iface_hold();
		test_stepping();
		test_cycle_loading();
		$display("tests run %0d, checks %0d, errors %0d", tests_run, checks, errors);
		if (errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* filelist.f */
hdl/cpu_timing_pkg.sv
hdl/strob_if.sv
hdl/panel_step.sv
hdl/cycle_decoder.sv
hdl/iface_guard.sv
hdl/strob_gen.sv
hdl/cpu_timing_top.sv
testbench/tb_cpu_timing.sv
